// ==== rtl/add_engine.sv ====
`timescale 1ns/1ps

module add_engine #(
    parameter int NUM_LIMBS = 2
) (
    input  logic                          clk,
    input  logic                          rst,
    input  adder_types_pkg::add_request_t req,
    output adder_types_pkg::add_result_t  res,
    output logic                          busy
);

    localparam int LB = adder_types_pkg::LIMB_BITS;
    localparam int IDX_W = (NUM_LIMBS > 1) ? $clog2(NUM_LIMBS) : 1;
    localparam logic [IDX_W-1:0] LAST_IDX = IDX_W'(NUM_LIMBS - 1);

    adder_types_pkg::engine_state_t state;
    logic [IDX_W-1:0]               idx;

    adder_types_pkg::word_t a_q;
    adder_types_pkg::word_t b_q;
    adder_types_pkg::word_t acc_q;
    adder_types_pkg::word_t acc_next;
    logic                   carry_q;

    adder_types_pkg::word_t sum_q;
    logic                   cout_q;

    adder_types_pkg::limb_t limb_a;
    adder_types_pkg::limb_t limb_b;
    adder_types_pkg::limb_t limb_sum;
    logic                   limb_cout;

    assign limb_a = a_q[idx*LB +: LB];
    assign limb_b = b_q[idx*LB +: LB];

    prefix_adder u_prefix_adder (
        .a    (limb_a),
        .b    (limb_b),
        .cin  (carry_q),
        .sum  (limb_sum),
        .cout (limb_cout)
    );

    // Accumulated sum with the current limb merged in.
    always_comb begin
        acc_next = acc_q;
        acc_next[idx*LB +: LB] = limb_sum;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state  <= adder_types_pkg::IDLE;
            idx    <= '0;
            sum_q  <= '0;
            cout_q <= 1'b0;
        end else begin
            case (state)
                adder_types_pkg::RUN: begin
                    if (idx == LAST_IDX) begin
                        state  <= adder_types_pkg::DONE;
                        sum_q  <= acc_next;
                        cout_q <= limb_cout;
                    end else begin
                        idx <= idx + 1'b1;
                    end
                end
                default: begin
                    if (req.start) begin
                        state <= adder_types_pkg::RUN;
                        idx   <= '0;
                    end
                end
            endcase
        end
    end

    // Datapath, loaded on start and stepped one limb per RUN cycle.
    always_ff @(posedge clk) begin
        if (state != adder_types_pkg::RUN && req.start) begin
            a_q     <= req.a;
            b_q     <= req.b;
            carry_q <= req.carry_in;
            acc_q   <= '0;
        end else if (state == adder_types_pkg::RUN) begin
            acc_q   <= acc_next;
            carry_q <= limb_cout;
        end
    end

    // Busy already in the cycle the start is taken.
    assign busy = (state == adder_types_pkg::RUN) || req.start;

    assign res = '{sum: sum_q, carry_out: cout_q, done: (state == adder_types_pkg::DONE)};

endmodule

// ==== rtl/adder_axil_top.sv ====
`timescale 1ns/1ps

module adder_axil_top #(
    parameter int NUM_LIMBS = 2
) (
    input  logic               clk,
    input  logic               rst,
    input  axil_pkg::axil_aw_t aw,
    output logic               awready,
    input  axil_pkg::axil_w_t  w,
    output logic               wready,
    output axil_pkg::axil_b_t  b,
    input  logic               bready,
    input  axil_pkg::axil_ar_t ar,
    output logic               arready,
    output axil_pkg::axil_r_t  r,
    input  logic               rready
);

    adder_types_pkg::add_request_t req;
    adder_types_pkg::add_result_t  res;
    logic                          busy;

    axil_write_side #(
        .NUM_LIMBS (NUM_LIMBS)
    ) u_write_side (
        .clk     (clk),
        .rst     (rst),
        .aw      (aw),
        .awready (awready),
        .w       (w),
        .wready  (wready),
        .b       (b),
        .bready  (bready),
        .req     (req)
    );

    add_engine #(
        .NUM_LIMBS (NUM_LIMBS)
    ) u_engine (
        .clk  (clk),
        .rst  (rst),
        .req  (req),
        .res  (res),
        .busy (busy)
    );

    axil_read_side u_read_side (
        .clk     (clk),
        .rst     (rst),
        .ar      (ar),
        .arready (arready),
        .r       (r),
        .rready  (rready),
        .res     (res),
        .busy    (busy)
    );

endmodule

// ==== rtl/adder_types_pkg.sv ====
package adder_types_pkg;

    // Width of one slice handled by the prefix adder per cycle.
    localparam int LIMB_BITS = 16;

    typedef logic [LIMB_BITS-1:0] limb_t;

    // Operand or result as held in a register, sized to the 32-bit bus.
    typedef logic [31:0] word_t;

    typedef enum logic [1:0] {
        IDLE,
        RUN,
        DONE
    } engine_state_t;

    // Operands and start pulse from the write side into the engine.
    typedef struct packed {
        word_t a;
        word_t b;
        logic  carry_in;
        logic  start;
    } add_request_t;

    typedef struct packed {
        word_t sum;
        logic  carry_out;
        logic  done;
    } add_result_t;

endpackage

// ==== rtl/axil_pkg.sv ====
package axil_pkg;

    typedef logic [7:0]  axil_addr_t;
    typedef logic [31:0] axil_data_t;
    typedef logic [1:0]  axil_resp_t;

    localparam axil_resp_t RESP_OKAY = 2'b00;

    typedef struct packed {
        axil_addr_t addr;
        logic       valid;
    } axil_aw_t;

    typedef struct packed {
        axil_data_t data;
        logic [3:0] strb;
        logic       valid;
    } axil_w_t;

    typedef struct packed {
        axil_resp_t resp;
        logic       valid;
    } axil_b_t;

    typedef struct packed {
        axil_addr_t addr;
        logic       valid;
    } axil_ar_t;

    typedef struct packed {
        axil_data_t data;
        axil_resp_t resp;
        logic       valid;
    } axil_r_t;

    // Register map.
    localparam axil_addr_t REG_A      = 8'h00;
    localparam axil_addr_t REG_B      = 8'h04;
    localparam axil_addr_t REG_CTRL   = 8'h08;
    localparam axil_addr_t REG_SUM    = 8'h0C;
    localparam axil_addr_t REG_STATUS = 8'h10;

endpackage

// ==== rtl/axil_read_side.sv ====
`timescale 1ns/1ps

module axil_read_side (
    input  logic                         clk,
    input  logic                         rst,
    input  axil_pkg::axil_ar_t           ar,
    output logic                         arready,
    output axil_pkg::axil_r_t            r,
    input  logic                         rready,
    input  adder_types_pkg::add_result_t res,
    input  logic                         busy
);

    logic                 r_valid;
    axil_pkg::axil_data_t r_data;
    axil_pkg::axil_data_t rd_mux;

    // One read in flight at a time.
    assign arready = !r_valid;

    always_comb begin
        case (ar.addr)
            axil_pkg::REG_SUM: begin
                rd_mux = res.sum;
            end
            axil_pkg::REG_STATUS: begin
                rd_mux = {29'd0, res.done, res.carry_out, busy};
            end
            default: begin
                rd_mux = '0;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            r_valid <= 1'b0;
            r_data  <= '0;
        end else begin
            if (ar.valid && arready) begin
                r_valid <= 1'b1;
                r_data  <= rd_mux;
            end else if (r_valid && rready) begin
                r_valid <= 1'b0;
            end
        end
    end

    assign r = '{data: r_data, resp: axil_pkg::RESP_OKAY, valid: r_valid};

endmodule

// ==== rtl/axil_write_side.sv ====
`timescale 1ns/1ps

module axil_write_side #(
    parameter int NUM_LIMBS = 2
) (
    input  logic                          clk,
    input  logic                          rst,
    input  axil_pkg::axil_aw_t            aw,
    output logic                          awready,
    input  axil_pkg::axil_w_t             w,
    output logic                          wready,
    output axil_pkg::axil_b_t             b,
    input  logic                          bready,
    output adder_types_pkg::add_request_t req
);

    localparam int OPER_BITS = NUM_LIMBS * adder_types_pkg::LIMB_BITS;
    localparam adder_types_pkg::word_t OPER_MASK =
        adder_types_pkg::word_t'((64'd1 << OPER_BITS) - 64'd1);

    logic                 aw_full;
    axil_pkg::axil_addr_t aw_addr_q;
    logic                 w_full;
    axil_pkg::axil_data_t w_data_q;
    logic                 b_valid;
    logic                 do_write;

    adder_types_pkg::word_t a_q;
    adder_types_pkg::word_t b_q;
    logic                   cin_q;
    logic                   start_q;

    // No new address or data while a response is outstanding.
    assign awready  = !aw_full && !b_valid;
    assign wready   = !w_full && !b_valid;
    assign do_write = aw_full && w_full;

    always_ff @(posedge clk) begin
        if (rst) begin
            aw_full <= 1'b0;
            w_full  <= 1'b0;
            b_valid <= 1'b0;
        end else begin
            if (do_write) begin
                aw_full <= 1'b0;
                w_full  <= 1'b0;
                b_valid <= 1'b1;
            end else begin
                if (aw.valid && awready) begin
                    aw_full <= 1'b1;
                end
                if (w.valid && wready) begin
                    w_full <= 1'b1;
                end
                if (b_valid && bready) begin
                    b_valid <= 1'b0;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (aw.valid && awready) begin
            aw_addr_q <= aw.addr;
        end
        if (w.valid && wready) begin
            w_data_q <= w.data;
        end
    end

    // Strobes are ignored; every write covers the full word.
    always_ff @(posedge clk) begin
        if (rst) begin
            a_q     <= '0;
            b_q     <= '0;
            cin_q   <= 1'b0;
            start_q <= 1'b0;
        end else begin
            start_q <= 1'b0;
            if (do_write) begin
                case (aw_addr_q)
                    axil_pkg::REG_A: a_q <= w_data_q & OPER_MASK;
                    axil_pkg::REG_B: b_q <= w_data_q & OPER_MASK;
                    axil_pkg::REG_CTRL: begin
                        cin_q   <= w_data_q[0];
                        start_q <= 1'b1;
                    end
                    default: ;
                endcase
            end
        end
    end

    assign b   = '{resp: axil_pkg::RESP_OKAY, valid: b_valid};
    assign req = '{a: a_q, b: b_q, carry_in: cin_q, start: start_q};

endmodule

// ==== rtl/prefix_adder.sv ====
`timescale 1ns/1ps

module prefix_adder (
    input  adder_types_pkg::limb_t a,
    input  adder_types_pkg::limb_t b,
    input  logic                   cin,
    output adder_types_pkg::limb_t sum,
    output logic                   cout
);

    localparam int W = adder_types_pkg::LIMB_BITS;
    localparam int TIERS = 4;

    // Column m holds bit position m-1, so column 0 is the carry-in.
    logic [W-1:0] gt [0:TIERS];
    logic [W-1:0] pt [0:TIERS];
    logic [W-1:0] half_sum;

    assign half_sum = a ^ b;

    always_comb begin
        int j;
        gt[0] = {a[W-2:0] & b[W-2:0], cin};
        pt[0] = {half_sum[W-2:0], 1'b0};
        for (int k = 0; k < TIERS; k++) begin
            for (int m = 0; m < W; m++) begin
                if (m[k]) begin
                    // Sklansky fan-out: the upper half of each block takes the
                    // top of the lower half.
                    j = ((m >> k) << k) - 1;
                    gt[k+1][m] = gt[k][m] | (pt[k][m] & gt[k][j]);
                    // Once the right group reaches the carry-in this is a gray
                    // cell and the group propagate is not needed again.
                    pt[k+1][m] = pt[k][m] & pt[k][j];
                end else begin
                    gt[k+1][m] = gt[k][m];
                    pt[k+1][m] = pt[k][m];
                end
            end
        end
    end

    // Final tier holds the carry into every bit position.
    assign sum = half_sum ^ gt[TIERS];

    // One extra gray cell for the top bit gives the carry-out.
    assign cout = (a[W-1] & b[W-1]) | (half_sum[W-1] & gt[TIERS][W-1]);

endmodule

// ==== run.sh ====
#!/usr/bin/env bash
# Builds the testbench with Verilator and runs it from the project root.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --top-module tb_adder_axil -f vlog.f -o sim_tb \
    && ./obj_dir/sim_tb | tee /dev/stderr | grep -q "Test completed successfully" \
    && echo "Simulation passed" \
    || { echo "Simulation failed"; exit 1; }

// ==== tests/tb_adder_axil.sv ====
`timescale 1ns/1ps

module tb_adder_axil;

    localparam int NUM_LIMBS = 2;
    localparam int TIMEOUT = 50;
    localparam int NUM_ADDS = 200;

    logic clk = 1'b0;
    logic rst;

    axil_pkg::axil_aw_t aw;
    logic               awready;
    axil_pkg::axil_w_t  w;
    logic               wready;
    axil_pkg::axil_b_t  b;
    logic               bready;
    axil_pkg::axil_ar_t ar;
    logic               arready;
    axil_pkg::axil_r_t  r;
    logic               rready;

    int          error_count = 0;
    int          timeout_count = 0;
    string       test_name = "none";
    logic [31:0] rng_state = 32'd46769;

    adder_axil_top #(
        .NUM_LIMBS (NUM_LIMBS)
    ) u_dut (
        .clk     (clk),
        .rst     (rst),
        .aw      (aw),
        .awready (awready),
        .w       (w),
        .wready  (wready),
        .b       (b),
        .bready  (bready),
        .ar      (ar),
        .arready (arready),
        .r       (r),
        .rready  (rready)
    );

    always #20 clk = ~clk;

    function automatic logic [31:0] next_rand();
        logic [31:0] x;
        x = rng_state;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        rng_state = x;
        return x;
    endfunction

    // Called and returns at a falling edge; ready is stable there until the next rising edge.
    task automatic axil_write(input logic [7:0] addr, input logic [31:0] data, input int hold);
        int   cycles;
        logic aw_done;
        logic w_done;
        aw_done = 1'b0;
        w_done = 1'b0;
        aw.addr = addr;
        aw.valid = 1'b1;
        w.data = data;
        w.strb = 4'hF;
        w.valid = 1'b1;
        cycles = 0;
        while (!(aw_done && w_done) && cycles < TIMEOUT) begin
            if (aw.valid && awready) begin
                aw_done = 1'b1;
            end
            if (w.valid && wready) begin
                w_done = 1'b1;
            end
            @(negedge clk);
            if (aw_done) begin
                aw.valid = 1'b0;
            end
            if (w_done) begin
                w.valid = 1'b0;
            end
            cycles++;
        end
        if (!(aw_done && w_done)) begin
            $display("Write to address %h was not accepted in time", addr);
            timeout_count++;
            aw.valid = 1'b0;
            w.valid = 1'b0;
        end else begin
            cycles = 0;
            while (!b.valid && cycles < TIMEOUT) begin
                @(negedge clk);
                cycles++;
            end
            if (!b.valid) begin
                $display("No write response for address %h", addr);
                timeout_count++;
            end else begin
                // Back-pressure on B.
                for (int i = 0; i <= hold; i++) begin
                    if (!b.valid) begin
                        $display("Write response dropped before it was accepted");
                        error_count++;
                    end
                    if (awready || wready) begin
                        $display("Write channels were ready while a response was pending");
                        error_count++;
                    end
                    if (i < hold) begin
                        @(negedge clk);
                    end
                end
                if (b.resp !== axil_pkg::RESP_OKAY) begin
                    $display("ERROR %s: expected %h, actual %h", test_name,
                             axil_pkg::RESP_OKAY, b.resp);
                    error_count++;
                end
                bready = 1'b1;
                @(negedge clk);
                bready = 1'b0;
            end
        end
    endtask

    task automatic axil_read(input logic [7:0] addr, input int hold, output logic [31:0] data);
        int          cycles;
        logic [31:0] first;
        data = '0;
        ar.addr = addr;
        ar.valid = 1'b1;
        cycles = 0;
        while (!arready && cycles < TIMEOUT) begin
            @(negedge clk);
            cycles++;
        end
        if (!arready) begin
            $display("Read of address %h was not accepted in time", addr);
            timeout_count++;
            ar.valid = 1'b0;
        end else begin
            @(negedge clk);
            ar.valid = 1'b0;
            cycles = 0;
            while (!r.valid && cycles < TIMEOUT) begin
                @(negedge clk);
                cycles++;
            end
            if (!r.valid) begin
                $display("No read data for address %h", addr);
                timeout_count++;
            end else begin
                first = r.data;
                for (int i = 0; i <= hold; i++) begin
                    if (!r.valid) begin
                        $display("Read data dropped before it was accepted");
                        error_count++;
                    end
                    if (r.data !== first) begin
                        $display("ERROR %s: expected %h, actual %h", test_name, first, r.data);
                        error_count++;
                    end
                    if (arready) begin
                        $display("Read address was ready while read data was pending");
                        error_count++;
                    end
                    if (i < hold) begin
                        @(negedge clk);
                    end
                end
                if (r.resp !== axil_pkg::RESP_OKAY) begin
                    $display("ERROR %s: expected %h, actual %h", test_name,
                             axil_pkg::RESP_OKAY, r.resp);
                    error_count++;
                end
                data = first;
                rready = 1'b1;
                @(negedge clk);
                rready = 1'b0;
            end
        end
    endtask

    initial begin
        logic [31:0] rd;
        logic [31:0] op_a;
        logic [31:0] op_b;
        logic        cin;
        logic [32:0] expected;
        int          hold_b;
        int          hold_r;
        int          polls;

        rst = 1'b1;
        aw = '0;
        w = '0;
        ar = '0;
        bready = 1'b0;
        rready = 1'b0;
        repeat (2) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        test_name = "reset";
        // Ready on AW, W and AR; no valid on B or R.
        if ({awready, wready, arready, b.valid, r.valid} !== 5'b11100) begin
            $display("ERROR %s: expected %b, actual %b", test_name, 5'b11100,
                     {awready, wready, arready, b.valid, r.valid});
            error_count++;
        end
        axil_read(axil_pkg::REG_SUM, 0, rd);
        if (rd !== 32'd0) begin
            $display("ERROR %s: expected %h, actual %h", test_name, 32'd0, rd);
            error_count++;
        end
        axil_read(axil_pkg::REG_STATUS, 0, rd);
        if (rd !== 32'd0) begin
            $display("ERROR %s: expected %h, actual %h", test_name, 32'd0, rd);
            error_count++;
        end

        for (int n = 0; n < NUM_ADDS; n++) begin
            op_a = next_rand();
            op_b = next_rand();
            cin = rng_state[7];
            // Corner cases lead the run.
            // Every seventh random A gets an all-ones low limb.
            case (n)
                0: begin
                    op_a = 32'hFFFF_FFFF;
                    op_b = 32'd0;
                    cin = 1'b1;
                end
                1: begin
                    op_a = 32'h0000_FFFF;
                    op_b = 32'd1;
                    cin = 1'b0;
                end
                2: begin
                    op_a = 32'hFFFF_FFFF;
                    op_b = 32'hFFFF_FFFF;
                    cin = 1'b1;
                end
                3: begin
                    op_a = 32'h0000_FFFF;
                    op_b = 32'd0;
                    cin = 1'b1;
                end
                default: begin
                    if (n % 7 == 0) begin
                        op_a[15:0] = 16'hFFFF;
                    end
                end
            endcase
            expected = {1'b0, op_a} + {1'b0, op_b} + {32'd0, cin};

            // Second half runs with random back-pressure on B and R.
            hold_b = 0;
            hold_r = 0;
            if (n >= NUM_ADDS / 2) begin
                hold_b = int'(next_rand() & 32'h7);
                hold_r = int'(next_rand() & 32'h7);
            end

            test_name = "add";
            axil_write(axil_pkg::REG_A, op_a, hold_b);
            axil_write(axil_pkg::REG_B, op_b, hold_b);
            axil_write(axil_pkg::REG_CTRL, {31'd0, cin}, hold_b);

            test_name = "busy";
            axil_read(axil_pkg::REG_STATUS, hold_r, rd);
            if (!(rd[0] || rd[2])) begin
                $display("ERROR %s: expected busy or done set, actual %h", test_name, rd);
                error_count++;
            end
            polls = 0;
            while (!rd[2] && polls < NUM_LIMBS + 2) begin
                axil_read(axil_pkg::REG_STATUS, hold_r, rd);
                polls++;
            end
            if (!rd[2]) begin
                $display("Addition %0d did not finish within %0d status reads", n, polls);
                error_count++;
            end

            test_name = "carry";
            if (rd[1] !== expected[32]) begin
                $display("ERROR %s: expected %h, actual %h", test_name, expected[32], rd[1]);
                error_count++;
            end
            test_name = "sum";
            axil_read(axil_pkg::REG_SUM, hold_r, rd);
            if (rd !== expected[31:0]) begin
                $display("ERROR %s: expected %h, actual %h", test_name, expected[31:0], rd);
                error_count++;
            end

            // New operands alone must not disturb the last result.
            if (n % 8 == 5) begin
                test_name = "hold";
                axil_write(axil_pkg::REG_A, next_rand(), hold_b);
                axil_write(axil_pkg::REG_B, next_rand(), hold_b);
                axil_read(axil_pkg::REG_SUM, hold_r, rd);
                if (rd !== expected[31:0]) begin
                    $display("ERROR %s: expected %h, actual %h", test_name, expected[31:0], rd);
                    error_count++;
                end
            end
        end

        $display("Errors: %0d, timeouts: %0d", error_count, timeout_count);
        if (error_count == 0 && timeout_count == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

// ==== vlog.f ====
rtl/adder_types_pkg.sv
rtl/axil_pkg.sv
rtl/prefix_adder.sv
rtl/add_engine.sv
rtl/axil_write_side.sv
rtl/axil_read_side.sv
rtl/adder_axil_top.sv
tests/tb_adder_axil.sv
